// File: Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# fails unless the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "TB PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/isa_pkg.sv
hw/predictor_pkg.sv
hw/fetch_stage.sv
hw/branch_predictor.sv
hw/fetch_config_regs.sv
hw/fetch_unit_top.sv
testbench/fetch_unit_assert.sv
testbench/fetch_unit_tb.sv

// File: hw/branch_predictor.sv
//////////////////////////////
// direct-mapped branch target buffer with 2-bit counters
// lookup is combinational on pc, retire updates land at the edge,
// clear_start walks through the table invalidating one entry a cycle
//////////////////////////////

`timescale 1ns/1ps

module branch_predictor import isa_pkg::*; import predictor_pkg::*; #(
  parameter int BTB_ENTRIES = 16         // power of two, 4 to 256
) (
  input  logic  clock,
  input  logic  reset,
  input  addr_t pc,                      // pc being fetched
  input  logic  bp_enable,
  input  logic  clear_start,             // one cycle pulse from config block
  input  logic  co_ret_branch_valid,     // retired branch, train on it
  input  logic  co_ret_take_branch,      // its outcome
  input  addr_t co_ret_pc,
  input  addr_t co_ret_target_pc,
  output addr_t bp_npc,
  output logic  bp_npc_valid,
  output logic  clear_busy
);

  // instructions are 4-byte aligned so the index starts above bit 1
  localparam int IDX_LO = INST_SEL_BIT;
  localparam int IDX_W  = $clog2(BTB_ENTRIES);
  localparam int TAG_LO = IDX_LO + IDX_W;
  localparam int TAG_W  = ADDR_W - TAG_LO;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  localparam idx_t LAST_IDX = idx_t'(BTB_ENTRIES - 1);

  //////////////////////////////
  // table storage
  //////////////////////////////
  logic [BTB_ENTRIES-1:0] valid_q;       // per entry valid, the only state reset clears
  tag_t                   tag_mem    [BTB_ENTRIES];
  addr_t                  target_mem [BTB_ENTRIES];
  counter_t               ctr_mem    [BTB_ENTRIES];

  clear_state_t clr_state;
  idx_t         clr_idx;                 // entry being invalidated

  idx_t lk_idx;
  tag_t lk_tag;
  logic lk_hit;
  logic lk_taken;

  idx_t rt_idx;
  tag_t rt_tag;
  logic rt_hit;
  logic upd_en;                          // retire write allowed this cycle
  logic alloc_en;                        // taken miss, claim the entry

  //////////////////////////////
  // lookup
  //////////////////////////////
  assign lk_idx   = pc[TAG_LO-1:IDX_LO];
  assign lk_tag   = pc[ADDR_W-1:TAG_LO];
  assign lk_hit   = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
  assign lk_taken = (ctr_mem[lk_idx] == weak_taken) || (ctr_mem[lk_idx] == strong_taken);

  assign bp_npc       = target_mem[lk_idx];
  assign bp_npc_valid = bp_enable & ~clear_busy & lk_hit & lk_taken;

  //////////////////////////////
  // retire update
  //////////////////////////////
  assign rt_idx   = co_ret_pc[TAG_LO-1:IDX_LO];
  assign rt_tag   = co_ret_pc[ADDR_W-1:TAG_LO];
  assign rt_hit   = valid_q[rt_idx] && (tag_mem[rt_idx] == rt_tag);
  assign upd_en   = co_ret_branch_valid & ~clear_busy;   // training paused during clear
  assign alloc_en = upd_en & ~rt_hit & co_ret_take_branch;

  // tag, target and counter carry no meaning while the valid bit is low
  always_ff @(posedge clock) begin
    if (alloc_en) begin
      tag_mem[rt_idx]    <= rt_tag;
      target_mem[rt_idx] <= co_ret_target_pc;
      ctr_mem[rt_idx]    <= weak_taken;                  // new entries start weakly taken
    end else if (upd_en && rt_hit) begin
      ctr_mem[rt_idx] <= counter_next(ctr_mem[rt_idx], co_ret_take_branch);
      if (co_ret_take_branch) begin
        target_mem[rt_idx] <= co_ret_target_pc;          // targets of indirects can move
      end
    end
  end

  // not-taken miss leaves the table alone
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (clr_state == clr_clearing) begin
      valid_q[clr_idx] <= 1'b0;
    end else if (alloc_en) begin
      valid_q[rt_idx] <= 1'b1;
    end
  end

  //////////////////////////////
  // clear fsm
  //////////////////////////////
  assign clear_busy = (clr_state == clr_clearing);

  // busy for exactly BTB_ENTRIES cycles, starting the cycle after clear_start
  always_ff @(posedge clock) begin
    if (reset) begin
      clr_state <= clr_idle;
      clr_idx   <= '0;
    end else begin
      case (clr_state)
        clr_idle: begin
          if (clear_start) begin
            clr_state <= clr_clearing;
            clr_idx   <= '0;
          end
        end
        default: begin
          clr_idx <= clr_idx + idx_t'(1);
          if (clr_idx == LAST_IDX) begin
            clr_state <= clr_idle;                       // last entry done this cycle
          end
        end
      endcase
    end
  end

endmodule

// File: hw/fetch_config_regs.sv
//////////////////////////////
// predictor config registers: CTRL holds the enable and takes
// clear requests, STATUS reports a clear in progress
//////////////////////////////

`timescale 1ns/1ps

module fetch_config_regs import predictor_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      cfg_write,   // write strobe, one cycle per write
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  input  logic      clear_busy,  // from predictor clear fsm
  output cfg_data_t cfg_rdata,
  output logic      bp_enable,
  output logic      clear_start  // single cycle pulse to predictor
);

  logic ctrl_wr;                 // write hits CTRL
  logic clear_req;               // clear bit written as 1

  assign ctrl_wr   = cfg_write && (cfg_addr == CFG_CTRL);
  assign clear_req = ctrl_wr && cfg_wdata[CTRL_CLEAR_BIT];

  always_ff @(posedge clock) begin
    if (reset) begin
      bp_enable   <= 1'b0;       // predictor off until software turns it on
      clear_start <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        bp_enable <= cfg_wdata[CTRL_ENABLE_BIT];
      end
      // drop requests while a clear runs or one is already on its way
      clear_start <= clear_req & ~clear_busy & ~clear_start;
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////
  always_comb begin
    cfg_rdata = '0;              // unmapped addresses read zero
    case (cfg_addr)
      CFG_CTRL:   cfg_rdata[CTRL_ENABLE_BIT] = bp_enable;
      CFG_STATUS: cfg_rdata[STATUS_BUSY_BIT] = clear_busy;
      default:    cfg_rdata = '0;
    endcase
  end

endmodule

// File: hw/fetch_stage.sv
//////////////////////////////
// instruction fetch stage: holds the pc, picks the next pc
// (retire redirect > prediction > pc+4) and selects one
// instruction out of the 64-bit imem word
//////////////////////////////

`timescale 1ns/1ps

module fetch_stage import isa_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_en,        // dispatch takes the fetched instruction
  input  logic      imem_valid,         // imem_data holds the word at imem_addr
  input  logic      co_ret_take_branch, // taken branch at retire, wins over all else
  input  addr_t     co_ret_target_pc,
  input  addr_t     bp_npc,             // predicted target for the current pc
  input  logic      bp_npc_valid,
  input  mem_word_t imem_data,
  output addr_t     imem_addr,
  output addr_t     pc,
  output addr_t     fetch_npc,
  output inst_t     fetch_inst,
  output logic      fetch_out_valid
);

  addr_t pc_plus_4;    // sequential successor
  addr_t next_pc;      // successor when the fetch is accepted
  logic  fetch_accept; // dispatch took a valid instruction this cycle

  //////////////////////////////
  // memory side
  //////////////////////////////

  // imem is addressed by 8-byte word, low bits forced to zero
  assign imem_addr = {pc[ADDR_W-1:WORD_ALIGN_BITS], {WORD_ALIGN_BITS{1'b0}}};

  // bit 2 of the pc picks which half of the word we are on
  assign fetch_inst = pc[INST_SEL_BIT] ? imem_data[MEM_WORD_W-1:INST_W]
                                       : imem_data[INST_W-1:0];

  assign fetch_out_valid = imem_valid;  // no extra qualification here

  //////////////////////////////
  // next pc
  //////////////////////////////

  assign pc_plus_4 = pc + addr_t'(INST_BYTES);
  assign fetch_npc = pc_plus_4;         // travels down the pipe with the inst

  assign fetch_accept = dispatch_en & imem_valid;

  // prediction only matters once the current fetch actually leaves
  assign next_pc = bp_npc_valid ? bp_npc : pc_plus_4;

  // the retire redirect is checked first so it is never lost to a stall
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;                         // boot address
    end else if (co_ret_take_branch) begin
      pc <= co_ret_target_pc;
    end else if (fetch_accept) begin
      pc <= next_pc;
    end
  end

endmodule

// File: hw/fetch_unit_top.sv
//////////////////////////////
// fetch front end: fetch stage, branch predictor and their
// config block; instruction memory sits outside
//////////////////////////////

`timescale 1ns/1ps

module fetch_unit_top import isa_pkg::*; import predictor_pkg::*; #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch_en,
  input  logic      imem_valid,
  input  mem_word_t imem_data,
  input  logic      co_ret_branch_valid,
  input  logic      co_ret_take_branch,
  input  addr_t     co_ret_pc,
  input  addr_t     co_ret_target_pc,
  input  logic      cfg_write,
  input  cfg_addr_t cfg_addr,
  input  cfg_data_t cfg_wdata,
  output addr_t     imem_addr,
  output addr_t     pc,
  output addr_t     fetch_npc,
  output inst_t     fetch_inst,
  output logic      fetch_out_valid,
  output cfg_data_t cfg_rdata
);

  // predictor <-> fetch
  addr_t bp_npc;
  logic  bp_npc_valid;

  // config <-> predictor
  logic  bp_enable;
  logic  clear_start;
  logic  clear_busy;

  fetch_stage u_fetch_stage (
    .clock              (clock),
    .reset              (reset),
    .dispatch_en        (dispatch_en),
    .imem_valid         (imem_valid),
    .co_ret_take_branch (co_ret_take_branch),
    .co_ret_target_pc   (co_ret_target_pc),
    .bp_npc             (bp_npc),
    .bp_npc_valid       (bp_npc_valid),
    .imem_data          (imem_data),
    .imem_addr          (imem_addr),
    .pc                 (pc),
    .fetch_npc          (fetch_npc),
    .fetch_inst         (fetch_inst),
    .fetch_out_valid    (fetch_out_valid)
  );

  branch_predictor #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_branch_predictor (
    .clock               (clock),
    .reset               (reset),
    .pc                  (pc),        // looked up in the same cycle it is fetched
    .bp_enable           (bp_enable),
    .clear_start         (clear_start),
    .co_ret_branch_valid (co_ret_branch_valid),
    .co_ret_take_branch  (co_ret_take_branch),
    .co_ret_pc           (co_ret_pc),
    .co_ret_target_pc    (co_ret_target_pc),
    .bp_npc              (bp_npc),
    .bp_npc_valid        (bp_npc_valid),
    .clear_busy          (clear_busy)
  );

  fetch_config_regs u_fetch_config_regs (
    .clock       (clock),
    .reset       (reset),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .clear_busy  (clear_busy),
    .cfg_rdata   (cfg_rdata),
    .bp_enable   (bp_enable),
    .clear_start (clear_start)
  );

endmodule

// File: hw/isa_pkg.sv
//////////////////////////////
// isa level types shared by fetch, predictor and testbench
// import with isa_pkg::* in the module header
//////////////////////////////

package isa_pkg;

  // widths of the fetch datapath
  localparam int ADDR_W     = 64;            // byte address / pc
  localparam int INST_W     = 32;            // one instruction
  localparam int MEM_WORD_W = 64;            // imem returns two instructions per word

  // byte step of one sequential instruction
  localparam int INST_BYTES = INST_W / 8;

  // low address bits dropped to align to one memory word
  localparam int WORD_ALIGN_BITS = $clog2(MEM_WORD_W / 8);

  // pc bit that selects the upper instruction in a memory word
  localparam int INST_SEL_BIT = $clog2(INST_BYTES);

  typedef logic [ADDR_W-1:0]     addr_t;     // byte address or pc
  typedef logic [INST_W-1:0]     inst_t;     // single instruction
  typedef logic [MEM_WORD_W-1:0] mem_word_t; // {inst at +4, inst at +0}

endpackage

// File: hw/predictor_pkg.sv
//////////////////////////////
// branch predictor definitions: counter states, clear fsm states
// and the config register map seen by software
//////////////////////////////

package predictor_pkg;

  // 2-bit saturating counter, msb set means predict taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_t;

  // walking clear of the target buffer
  typedef enum logic {
    clr_idle,
    clr_clearing
  } clear_state_t;

  //////////////////////////////
  // config register map
  //////////////////////////////
  typedef logic [1:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  localparam cfg_addr_t CFG_CTRL   = 2'd0;   // [0] enable, [1] clear request (write 1)
  localparam cfg_addr_t CFG_STATUS = 2'd1;   // [0] clear_busy

  localparam int CTRL_ENABLE_BIT = 0;
  localparam int CTRL_CLEAR_BIT  = 1;
  localparam int STATUS_BUSY_BIT = 0;

  // one step of the counter toward the branch outcome, holds at either end
  function automatic counter_t counter_next(input counter_t cur, input logic taken);
    counter_t nxt;
    case (cur)
      strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
      weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
      default:          nxt = taken ? strong_taken   : weak_taken;
    endcase
    return nxt;
  endfunction

endpackage

// File: testbench/fetch_unit_assert.sv
//////////////////////////////
// bound checks on the fetch front end: aligned imem address,
// retire redirect priority and length of a table clear
//////////////////////////////

`timescale 1ns/1ps

module fetch_unit_assert import isa_pkg::*; #(
  parameter int BTB_ENTRIES = 16
) (
  input logic  clock,
  input logic  reset,
  input addr_t imem_addr,
  input addr_t pc,
  input logic  co_ret_take_branch,
  input addr_t co_ret_target_pc,
  input logic  clear_start,
  input logic  clear_busy
);

  int busy_run;                                // consecutive cycles clear_busy was high

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_run <= 0;
    end else begin
      busy_run <= clear_busy ? busy_run + 1 : 0;
    end
  end

  a_imem_aligned: assert property (@(posedge clock) disable iff (reset)
    imem_addr[2:0] == 3'b000)
    else $error("imem_addr %h not on an 8-byte boundary", imem_addr);

  a_redirect: assert property (@(posedge clock) disable iff (reset)
    co_ret_take_branch |=> pc == $past(co_ret_target_pc))
    else $error("pc %h missed the retire redirect", pc);

  a_clear_starts: assert property (@(posedge clock) disable iff (reset)
    clear_start |=> clear_busy)
    else $error("clear did not start after clear_start");

  a_clear_bound: assert property (@(posedge clock) disable iff (reset)
    clear_busy |-> busy_run < BTB_ENTRIES)
    else $error("clear ran past %0d cycles", BTB_ENTRIES);

  a_clear_length: assert property (@(posedge clock) disable iff (reset)
    $fell(clear_busy) |-> busy_run == BTB_ENTRIES)
    else $error("clear ended after %0d cycles", busy_run);

endmodule

// fetch side has no clear logic
bind fetch_stage fetch_unit_assert u_fetch_stage_assert (
  .clock              (clock),
  .reset              (reset),
  .imem_addr          (imem_addr),
  .pc                 (pc),
  .co_ret_take_branch (co_ret_take_branch),
  .co_ret_target_pc   (co_ret_target_pc),
  .clear_start        (1'b0),
  .clear_busy         (1'b0)
);

// predictor sees no imem address
bind branch_predictor fetch_unit_assert #(
  .BTB_ENTRIES (BTB_ENTRIES)
) u_branch_predictor_assert (
  .clock              (clock),
  .reset              (reset),
  .imem_addr          ('0),
  .pc                 (pc),
  .co_ret_take_branch (co_ret_take_branch),
  .co_ret_target_pc   (co_ret_target_pc),
  .clear_start        (clear_start),
  .clear_busy         (clear_busy)
);

// File: testbench/fetch_unit_tb.sv
//////////////////////////////
// testbench for the fetch front end: models imem, drives fetch,
// retire and config ports, checks pc, instructions and registers
//////////////////////////////

`timescale 1ns/1ps

module fetch_unit_tb import isa_pkg::*; import predictor_pkg::*; ();

  localparam int BTB_ENTRIES = 16;
  localparam int MEM_WORDS   = 512;            // 4 KiB of instruction space
  localparam int WAIT_LIMIT  = 200;            // max cycles for any wait

  localparam addr_t BR_A  = 64'h120;           // branch trained then untrained
  localparam addr_t TGT_A = 64'h1c8;
  localparam addr_t BR_B  = 64'h180;           // branch wiped by the clear
  localparam addr_t TGT_B = 64'h240;
  localparam addr_t REDIR = 64'h300;

  logic      clock;
  logic      reset;
  logic      dispatch_en;
  logic      imem_valid;
  mem_word_t imem_data;
  logic      co_ret_branch_valid;
  logic      co_ret_take_branch;
  addr_t     co_ret_pc;
  addr_t     co_ret_target_pc;
  logic      cfg_write;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  addr_t     imem_addr;
  addr_t     pc;
  addr_t     fetch_npc;
  inst_t     fetch_inst;
  logic      fetch_out_valid;
  cfg_data_t cfg_rdata;

  mem_word_t   imem [MEM_WORDS];
  addr_t       model_pc;                       // expected pc, kept across tests

  fetch_unit_top #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) u_fetch_unit_top (.*);

  assign imem_data = imem[imem_addr[11:3]];    // imem word at the current address

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // instruction held at byte address a mixes every address bit
  function automatic inst_t inst_at(input addr_t a);
    return inst_t'(a[31:0] * 32'h9e37_79b1) ^ a[63:32] ^ 32'h0000_0013;
  endfunction

  task automatic fill_imem();
    addr_t base;
    for (int i = 0; i < MEM_WORDS; i++) begin
      base    = addr_t'(i) << 3;
      imem[i] = {inst_at(base + 64'd4), inst_at(base)};
    end
  endtask

  //////////////////////////////
  // compare and stop
  //////////////////////////////
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "first error reached");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_cfg(input string name, input cfg_data_t got, input cfg_data_t exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("CHECK FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp));
  endtask

  //////////////////////////////
  // bus helpers
  //////////////////////////////
  task automatic next_cycle();
    @(posedge clock);
    #1;                                        // inputs move 1 ns after the edge
  endtask

  task automatic retire_branch(input logic train, input logic taken,
                               input addr_t bpc, input addr_t target);
    co_ret_branch_valid = train;
    co_ret_take_branch  = taken;
    co_ret_pc           = bpc;
    co_ret_target_pc    = target;
    next_cycle();
    co_ret_branch_valid = 1'b0;
    co_ret_take_branch  = 1'b0;
  endtask

  task automatic write_cfg(input cfg_addr_t a, input cfg_data_t d);
    cfg_write = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    next_cycle();
    cfg_write = 1'b0;
  endtask

  task automatic read_cfg(input cfg_addr_t a, output cfg_data_t d);
    cfg_addr = a;
    #1;                                        // read mux is combinational
    d = cfg_rdata;
  endtask

  // let fetch run with data always valid until pc lands on target
  task automatic run_to_pc(input addr_t target);
    dispatch_en = 1'b1;
    imem_valid  = 1'b1;
    for (int n = 0; n < WAIT_LIMIT && pc !== target; n++) next_cycle();
    if (pc !== target) stop_run($sformatf("timeout, fetch never reached pc %h", target));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  // pc moves by 4 only on an accepted fetch under random stalls
  task automatic run_fetch(input int cycles, input logic random_dispatch);
    logic accept;
    for (int n = 0; n < cycles; n++) begin
      imem_valid  = ($urandom % 4) != 0;
      dispatch_en = random_dispatch ? logic'(($urandom % 3) != 0) : 1'b1;
      #1;
      check_addr("pc", pc, model_pc);
      check_addr("imem_addr", imem_addr, model_pc & ~addr_t'(7));
      check_addr("fetch_npc", fetch_npc, model_pc + 64'd4);
      check_flag("fetch_out_valid", fetch_out_valid, imem_valid);
      if (imem_valid) check_inst("fetch_inst", fetch_inst, inst_at(model_pc));
      accept = dispatch_en & imem_valid;
      next_cycle();
      if (accept) model_pc = model_pc + 64'd4;
    end
  endtask

  task automatic sequential_test();
    cfg_data_t rd;
    read_cfg(CFG_CTRL, rd);
    check_cfg("ctrl", rd, 8'h00);              // predictor off out of reset
    next_cycle();
    model_pc = '0;
    run_fetch(24, 1'b0);
    run_fetch(40, 1'b1);                       // back-pressure and imem stalls
  endtask

  task automatic redirect_test();
    dispatch_en = 1'b0;
    imem_valid  = 1'b1;
    retire_branch(1'b0, 1'b1, '0, 64'h200);    // redirect while dispatch stalls
    check_addr("pc", pc, 64'h200);
    next_cycle();
    check_addr("pc", pc, 64'h200);
    dispatch_en = 1'b1;
    retire_branch(1'b0, 1'b1, '0, 64'h33c);
    check_addr("pc", pc, 64'h33c);
    check_inst("fetch_inst", fetch_inst, inst_at(64'h33c));
  endtask

  task automatic predict_test();
    write_cfg(CFG_CTRL, 8'h01);
    retire_branch(1'b1, 1'b1, BR_A, TGT_A);    // allocates and redirects
    check_addr("pc", pc, TGT_A);
    retire_branch(1'b0, 1'b1, '0, BR_A - 64'd8);
    run_to_pc(BR_A);
    next_cycle();
    check_addr("pc", pc, TGT_A);
    // retire redirect beats a live prediction at BR_A
    retire_branch(1'b0, 1'b1, '0, BR_A);
    retire_branch(1'b0, 1'b1, '0, REDIR);
    check_addr("pc", pc, REDIR);
    retire_branch(1'b1, 1'b0, BR_A, '0);
    retire_branch(1'b1, 1'b0, BR_A, '0);       // now strongly not taken
    retire_branch(1'b0, 1'b1, '0, BR_A - 64'd8);
    run_to_pc(BR_A);
    next_cycle();
    check_addr("pc", pc, BR_A + 64'd4);
  endtask

  task automatic config_clear_test();
    cfg_data_t rd;
    int        busy_cycles;
    write_cfg(CFG_CTRL, 8'h00);
    read_cfg(CFG_CTRL, rd);
    check_cfg("ctrl", rd, 8'h00);
    next_cycle();
    write_cfg(CFG_CTRL, 8'h01);
    read_cfg(CFG_CTRL, rd);
    check_cfg("ctrl", rd, 8'h01);
    next_cycle();
    retire_branch(1'b1, 1'b1, BR_B, TGT_B);
    retire_branch(1'b0, 1'b1, '0, BR_B);
    next_cycle();
    check_addr("pc", pc, TGT_B);               // predicted before the clear
    write_cfg(CFG_CTRL, 8'h03);                // keep enable, request clear
    read_cfg(CFG_STATUS, rd);
    for (int n = 0; n < WAIT_LIMIT && rd[STATUS_BUSY_BIT] !== 1'b1; n++) begin
      next_cycle();
      read_cfg(CFG_STATUS, rd);
    end
    if (rd[STATUS_BUSY_BIT] !== 1'b1) stop_run("timeout, clear_busy never rose");
    busy_cycles = 0;
    for (int n = 0; n < WAIT_LIMIT && rd[STATUS_BUSY_BIT] === 1'b1; n++) begin
      busy_cycles++;
      next_cycle();
      read_cfg(CFG_STATUS, rd);
    end
    check_cfg("status", rd, 8'h00);
    if (busy_cycles != BTB_ENTRIES)
      stop_run($sformatf("CHECK FAILED t=%0t clear_busy cycles got=%0d exp=%0d",
                         $time, busy_cycles, BTB_ENTRIES));
    next_cycle();
    retire_branch(1'b0, 1'b1, '0, BR_B);
    next_cycle();
    check_addr("pc", pc, BR_B + 64'd4);        // entry is gone
  endtask

  initial begin
    void'($urandom(88526));
    reset               = 1'b1;
    dispatch_en         = 1'b0;
    imem_valid          = 1'b0;
    co_ret_branch_valid = 1'b0;
    co_ret_take_branch  = 1'b0;
    co_ret_pc           = '0;
    co_ret_target_pc    = '0;
    cfg_write           = 1'b0;
    cfg_addr            = '0;
    cfg_wdata           = '0;
    fill_imem();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    sequential_test();
    redirect_test();
    predict_test();
    config_clear_test();
    $display("TB PASSED");
    $finish;
  end

endmodule
